// File: Bender.yml
package:
  name: tex_cache_core

sources:
  - files:
      - tex_pix_pkg.sv
      - tex_axi_pkg.sv
      - tex_req_dispatch.sv
      - tex_l1_cache.sv
      - tex_fetch_arbiter.sv
      - tex_cache_core.sv
  - target: test
    files:
      - tb_tex_cache_core.sv

// File: tb_tex_cache_core.sv
// ----------------------------------------------------------------------
// texture cache testbench
// golden-driven reads on both ports against a stalling memory model,
// with burst, latency, border, endian and clear checks
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tb_tex_cache_core;

	localparam int l1_cache_num = 2;
	localparam int tag_addr_w   = 4;
	localparam int stride_w     = 16;
	localparam int ax           = tex_pix_pkg::addr_x_w;
	localparam int ay           = tex_pix_pkg::addr_y_w;
	localparam int pw           = tex_pix_pkg::pix_w;
	localparam int max_entries  = 64;
	// 8 pixels of 4 bytes per line
	localparam int line_bytes   = 8 * 4;

	localparam logic [31:0] tex_base   = 32'h0000_1000;
	localparam logic [31:0] tex_stride = 32'd256;
	localparam logic [31:0] data_key   = 32'h5a5a_0000;

	// golden columns
	localparam int f_test = 0;
	localparam int f_port = 1;
	localparam int f_x    = 2;
	localparam int f_y    = 3;
	localparam int f_end  = 4;
	localparam int f_exp  = 5;

	logic                                      clk;
	logic                                      rst_n;
	logic [tex_axi_pkg::axi_addr_w-1:0]        param_addr;
	logic [ax-1:0]                             param_width;
	logic [ay-1:0]                             param_height;
	logic [stride_w-1:0]                       param_stride;
	logic                                      endian;
	logic                                      clear_start;
	logic                                      clear_busy;
	logic [l1_cache_num*ax-1:0]                s_araddrx;
	logic [l1_cache_num*ay-1:0]                s_araddry;
	logic [l1_cache_num-1:0]                   s_arvalid;
	logic [l1_cache_num-1:0]                   s_arready;
	logic [l1_cache_num*pw-1:0]                s_rdata;
	logic [l1_cache_num-1:0]                   s_rvalid;
	logic [l1_cache_num-1:0]                   s_rready;
	logic [tex_axi_pkg::axi_addr_w-1:0]        m_axi4_araddr;
	logic                                      m_axi4_arvalid;
	logic                                      m_axi4_arready;
	logic [tex_axi_pkg::axi_data_w-1:0]        m_axi4_rdata;
	logic                                      m_axi4_rlast;
	logic                                      m_axi4_rvalid;
	logic                                      m_axi4_rready;

	logic [31:0] gold [max_entries*6];
	logic [31:0] burst_log [$];
	logic [31:0] rng = 32'ha2b2_f21a;
	logic [31:0] bus_addr;
	logic        bus_busy;
	int          beat;
	int          n_entries;
	int          cycles;
	int          cycle_limit;
	int          n_err;
	int          last_port;
	logic [ax-1:0] req_x   [2];
	logic [ay-1:0] req_y   [2];
	logic [31:0]   rd_data [2];
	int            rd_rise [2];

	tex_cache_core #(
		.l1_cache_num (l1_cache_num),
		.tag_addr_w   (tag_addr_w),
		.stride_w     (stride_w)
	) i_tex_cache_core (
		.clk            (clk),
		.rst_n          (rst_n),
		.param_addr     (param_addr),
		.param_width    (param_width),
		.param_height   (param_height),
		.param_stride   (param_stride),
		.endian         (endian),
		.clear_start    (clear_start),
		.clear_busy     (clear_busy),
		.s_araddrx      (s_araddrx),
		.s_araddry      (s_araddry),
		.s_arvalid      (s_arvalid),
		.s_arready      (s_arready),
		.s_rdata        (s_rdata),
		.s_rvalid       (s_rvalid),
		.s_rready       (s_rready),
		.m_axi4_araddr  (m_axi4_araddr),
		.m_axi4_arvalid (m_axi4_arvalid),
		.m_axi4_arready (m_axi4_arready),
		.m_axi4_rdata   (m_axi4_rdata),
		.m_axi4_rlast   (m_axi4_rlast),
		.m_axi4_rvalid  (m_axi4_rvalid),
		.m_axi4_rready  (m_axi4_rready)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] field(input int e, input int f);
		return gold[e*6+f];
	endfunction

	// line address from base, row offset and block number
	function automatic logic [31:0] line_addr(input int e);
		logic [31:0] blk;
		blk = field(e, f_x) >> tex_pix_pkg::blk_x_size;
		return tex_base + field(e, f_y) * tex_stride + blk * line_bytes;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			1: return "cold miss";
			2: return "line hit";
			3: return "border";
			4: return "two-port miss";
			5: return "endian swap";
			6: return "clear and refetch";
			default: return "unknown";
		endcase
	endfunction

	// ------------------------------------------------------------------
	// memory model returning each beat as its byte address xor a key
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			m_axi4_arready <= 1'b0;
			m_axi4_rvalid  <= 1'b0;
			m_axi4_rlast   <= 1'b0;
			bus_busy        = 1'b0;
			beat            = 0;
		end else begin
			rng = xorshift(rng);
			if (m_axi4_arvalid && m_axi4_arready) begin
				bus_addr = m_axi4_araddr;
				bus_busy = 1'b1;
				beat     = 0;
				burst_log.push_back(m_axi4_araddr);
			end
			if (m_axi4_rvalid && m_axi4_rready) begin
				beat = beat + 1;
				if (beat == tex_axi_pkg::burst_beats) begin
					bus_busy = 1'b0;
				end
			end
			m_axi4_arready <= !bus_busy && (rng[1:0] != 2'b00);
			if (m_axi4_rvalid && !m_axi4_rready) begin
				// beat not taken yet, hold it
			end else if (bus_busy && rng[3:2] != 2'b00) begin
				m_axi4_rvalid <= 1'b1;
				m_axi4_rdata  <= (bus_addr + beat * tex_axi_pkg::beat_bytes) ^ data_key;
				m_axi4_rlast  <= (beat == tex_axi_pkg::burst_beats - 1);
			end else begin
				m_axi4_rvalid <= 1'b0;
				m_axi4_rlast  <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// drives the ports in use_port together and waits for every response
	task issue_reads(input logic [1:0] use_port, input int hold);
		int          p;
		int          cyc;
		logic [1:0]  acc;
		logic [1:0]  seen;
		logic [1:0]  done;
		int          acc_cyc [2];
		int          held    [2];
		logic [31:0] first   [2];
		acc  = ~use_port;
		seen = ~use_port;
		done = ~use_port;
		cyc  = 0;
		@(posedge clk);
		for (p = 0; p < 2; p++) begin
			held[p] = 0;
			if (use_port[p]) begin
				s_araddrx[p*ax +: ax] <= req_x[p];
				s_araddry[p*ay +: ay] <= req_y[p];
				s_arvalid[p]          <= 1'b1;
				s_rready[p]           <= (hold == 0);
			end
		end
		while (done != 2'b11) begin
			@(posedge clk);
			cyc++;
			for (p = 0; p < 2; p++) begin
				if (!acc[p]) begin
					if (s_arvalid[p] && s_arready[p]) begin
						acc[p]       = 1'b1;
						acc_cyc[p]   = cyc;
						s_arvalid[p] <= 1'b0;
					end
				end else if (!done[p] && s_rvalid[p]) begin
					// the edge before this sample raised s_rvalid
					if (!seen[p]) begin
						seen[p]    = 1'b1;
						rd_rise[p] = cyc - acc_cyc[p] - 1;
						first[p]   = s_rdata[p*pw +: pw];
					end else if (s_rdata[p*pw +: pw] !== first[p]) begin
						$display("ERR port %0d s_rdata: %h changed to %h with s_rready low",
						         p, first[p], s_rdata[p*pw +: pw]);
						n_err++;
					end
					if (s_rready[p]) begin
						done[p]    = 1'b1;
						rd_data[p] = s_rdata[p*pw +: pw];
					end else begin
						held[p]++;
						if (held[p] >= hold) begin
							s_rready[p] <= 1'b1;
						end
					end
				end else if (!done[p] && seen[p]) begin
					$display("port %0d dropped s_rvalid before the response was taken", p);
					n_err++;
				end
			end
		end
		s_rready <= '1;
	endtask

	task read_entry(input int e, input int hold);
		int p;
		p        = field(e, f_port);
		req_x[p] = ax'(field(e, f_x));
		req_y[p] = ay'(field(e, f_y));
		endian  <= (field(e, f_end) != 0);
		issue_reads(2'b01 << p, hold);
		if (rd_data[p] !== field(e, f_exp)) begin
			$display("ERR entry %0d s_rdata[%0d]: got %h expected %h",
			         e, p, rd_data[p], field(e, f_exp));
			n_err++;
		end
	endtask

	task single_read(input int e);
		int p;
		int nb;
		p  = field(e, f_port);
		nb = burst_log.size();
		read_entry(e, 0);
		if (field(e, f_test) == 1) begin
			if (burst_log.size() != nb + 1) begin
				$display("entry %0d: expected one burst, saw %0d", e, burst_log.size() - nb);
				n_err++;
			end else if (burst_log[nb] !== line_addr(e)) begin
				$display("ERR entry %0d m_axi4_araddr: got %h expected %h",
				         e, burst_log[nb], line_addr(e));
				n_err++;
			end
		end
		if (field(e, f_test) == 2 || field(e, f_test) == 3) begin
			if (burst_log.size() != nb) begin
				$display("entry %0d: read went to the bus", e);
				n_err++;
			end
			if (rd_rise[p] != 2) begin
				$display("entry %0d: s_rvalid rose %0d cycles after acceptance, not 2",
				         e, rd_rise[p]);
				n_err++;
			end
		end
		if (burst_log.size() > nb) begin
			last_port = p;
		end
	endtask

	task paired_reads(input int e);
		int k;
		int p;
		int nb;
		int first_p;
		int ent_of [2];
		if (field(e, f_port) == field(e + 1, f_port)) begin
			$display("entries %0d and %0d are not on two ports", e, e + 1);
			n_err++;
			return;
		end
		for (k = 0; k < 2; k++) begin
			p         = field(e + k, f_port);
			ent_of[p] = e + k;
			req_x[p]  = ax'(field(e + k, f_x));
			req_y[p]  = ay'(field(e + k, f_y));
		end
		nb      = burst_log.size();
		endian <= (field(e, f_end) != 0);
		issue_reads(2'b11, 0);
		for (p = 0; p < 2; p++) begin
			if (rd_data[p] !== field(ent_of[p], f_exp)) begin
				$display("ERR entry %0d s_rdata[%0d]: got %h expected %h",
				         ent_of[p], p, rd_data[p], field(ent_of[p], f_exp));
				n_err++;
			end
		end
		// the grant goes first to the port after the one served last
		first_p = (last_port + 1) % 2;
		if (burst_log.size() != nb + 2) begin
			$display("entry %0d: expected two bursts, saw %0d", e, burst_log.size() - nb);
			n_err++;
		end else begin
			if (burst_log[nb] !== line_addr(ent_of[first_p])) begin
				$display("ERR entry %0d m_axi4_araddr: got %h expected %h",
				         ent_of[first_p], burst_log[nb], line_addr(ent_of[first_p]));
				n_err++;
			end
			if (burst_log[nb+1] !== line_addr(ent_of[1-first_p])) begin
				$display("ERR entry %0d m_axi4_araddr: got %h expected %h",
				         ent_of[1-first_p], burst_log[nb+1], line_addr(ent_of[1-first_p]));
				n_err++;
			end
			last_port = 1 - first_p;
		end
	endtask

	task clear_and_reread(input int e);
		int nb;
		int n_busy;
		nb = burst_log.size();
		read_entry(e, 0);
		if (burst_log.size() != nb) begin
			$display("entry %0d: read before the clear missed the cache", e);
			n_err++;
		end
		clear_start <= 1'b1;
		@(posedge clk);
		clear_start <= 1'b0;
		@(posedge clk);
		n_busy = 0;
		while (clear_busy) begin
			n_busy++;
			@(posedge clk);
		end
		if (n_busy == 0) begin
			$display("entry %0d: clear_busy did not rise after clear_start", e);
			n_err++;
		end else if (n_busy != (1 << tag_addr_w)) begin
			$display("entry %0d: clear_busy high for %0d cycles, not %0d",
			         e, n_busy, 1 << tag_addr_w);
			n_err++;
		end
		// held response checks that s_rdata stays put
		nb = burst_log.size();
		read_entry(e, 4);
		if (burst_log.size() != nb + 1) begin
			$display("entry %0d: read after the clear did not refetch the line", e);
			n_err++;
		end else if (burst_log[nb] !== line_addr(e)) begin
			$display("ERR entry %0d m_axi4_araddr: got %h expected %h",
			         e, burst_log[nb], line_addr(e));
			n_err++;
		end else begin
			last_port = field(e, f_port);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int i;
		int t;
		int t_err;
		int n_tests;
		int n_failed;
		clk            = 1'b0;
		rst_n          = 1'b0;
		param_addr     = tex_base;
		param_width    = 12'd40;
		param_height   = 12'd20;
		param_stride   = 16'd256;
		endian         = 1'b0;
		clear_start    = 1'b0;
		s_araddrx      = '0;
		s_araddry      = '0;
		s_arvalid      = '0;
		s_rready       = '1;
		m_axi4_arready = 1'b0;
		m_axi4_rdata   = '0;
		m_axi4_rlast   = 1'b0;
		m_axi4_rvalid  = 1'b0;
		cycles         = 0;
		n_err          = 0;
		n_tests        = 0;
		n_failed       = 0;
		last_port      = l1_cache_num - 1;
		foreach (gold[k]) begin
			gold[k] = '1;
		end
		$readmemh("tex_cache_golden.hex", gold);
		n_entries = 0;
		while (n_entries < max_entries && gold[n_entries*6] !== '1) begin
			n_entries++;
		end
		if (n_entries == 0) begin
			$display("golden file holds no entries");
			n_err++;
		end
		cycle_limit = n_entries * 64 + 200;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		i = 0;
		while (i < n_entries) begin
			t     = field(i, f_test);
			t_err = n_err;
			while (i < n_entries && field(i, f_test) == t) begin
				case (t)
					1, 2, 3, 5: begin
						single_read(i);
						i = i + 1;
					end
					4: begin
						paired_reads(i);
						i = i + 2;
					end
					6: begin
						clear_and_reread(i);
						i = i + 1;
					end
					default: begin
						$display("entry %0d has unknown test number %0d", i, t);
						n_err++;
						i = i + 1;
					end
				endcase
			end
			n_tests++;
			if (n_err == t_err) begin
				$display("test %0d %s: ok", t, test_name(t));
			end else begin
				n_failed++;
				$display("test %0d %s: %0d errors", t, test_name(t), n_err - t_err);
			end
		end

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_err);
		if (n_err == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tex_axi_pkg.sv
// ----------------------------------------------------------------------
// memory bus package
// read bus widths and the fixed line burst
// ----------------------------------------------------------------------

`default_nettype none

package tex_axi_pkg;

	localparam int axi_addr_w  = 32;
	localparam int axi_data_w  = 32;

	// every line fill is one burst of this many beats
	localparam int burst_beats = 8;

	// byte step between two beats
	localparam int beat_bytes  = axi_data_w / 8;

endpackage

`default_nettype wire

// File: tex_cache_core.f
tex_pix_pkg.sv
tex_axi_pkg.sv
tex_req_dispatch.sv
tex_l1_cache.sv
tex_fetch_arbiter.sv
tex_cache_core.sv
tb_tex_cache_core.sv

// File: tex_cache_core.sv
// ----------------------------------------------------------------------
// texture cache top level
// request dispatcher, one L1 cache per port and the shared fetch
// arbiter on the memory read bus
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tex_cache_core #(
	parameter int l1_cache_num = 2,
	parameter int tag_addr_w   = 4,
	parameter int stride_w     = 16
) (
	input  logic                                           clk,
	input  logic                                           rst_n,

	input  logic [tex_axi_pkg::axi_addr_w-1:0]             param_addr,
	input  logic [tex_pix_pkg::addr_x_w-1:0]               param_width,
	input  logic [tex_pix_pkg::addr_y_w-1:0]               param_height,
	input  logic [stride_w-1:0]                            param_stride,
	input  logic                                           endian,

	input  logic                                           clear_start,
	output logic                                           clear_busy,

	input  logic [l1_cache_num*tex_pix_pkg::addr_x_w-1:0] s_araddrx,
	input  logic [l1_cache_num*tex_pix_pkg::addr_y_w-1:0] s_araddry,
	input  logic [l1_cache_num-1:0]                        s_arvalid,
	output logic [l1_cache_num-1:0]                        s_arready,
	output logic [l1_cache_num*tex_pix_pkg::pix_w-1:0]    s_rdata,
	output logic [l1_cache_num-1:0]                        s_rvalid,
	input  logic [l1_cache_num-1:0]                        s_rready,

	// memory read bus
	output logic [tex_axi_pkg::axi_addr_w-1:0]             m_axi4_araddr,
	output logic                                           m_axi4_arvalid,
	input  logic                                           m_axi4_arready,
	input  logic [tex_axi_pkg::axi_data_w-1:0]             m_axi4_rdata,
	input  logic                                           m_axi4_rlast,
	input  logic                                           m_axi4_rvalid,
	output logic                                           m_axi4_rready
);

	localparam int ax = tex_pix_pkg::addr_x_w;
	localparam int ay = tex_pix_pkg::addr_y_w;
	localparam int pw = tex_pix_pkg::pix_w;
	localparam int bx = ax - tex_pix_pkg::blk_x_size;

	logic [l1_cache_num*ax-1:0]     q_addrx;
	logic [l1_cache_num*ay-1:0]     q_addry;
	logic [l1_cache_num-1:0]        q_border;
	logic [l1_cache_num-1:0]        q_valid;
	logic [l1_cache_num-1:0]        q_ready;
	logic [l1_cache_num*bx-1:0]     miss_blk_x;
	logic [l1_cache_num*ay-1:0]     miss_y;
	logic [l1_cache_num-1:0]        miss_valid;
	logic [l1_cache_num-1:0]        miss_ready;
	logic [tex_pix_pkg::line_w-1:0] fill_line;
	logic [l1_cache_num-1:0]        fill_valid;
	logic [l1_cache_num-1:0]        clr_busy;

	tex_req_dispatch #(
		.l1_cache_num (l1_cache_num)
	) i_tex_req_dispatch (
		.clk          (clk),
		.rst_n        (rst_n),
		.param_width  (param_width),
		.param_height (param_height),
		.s_araddrx    (s_araddrx),
		.s_araddry    (s_araddry),
		.s_arvalid    (s_arvalid),
		.s_arready    (s_arready),
		.q_addrx      (q_addrx),
		.q_addry      (q_addry),
		.q_border     (q_border),
		.q_valid      (q_valid),
		.q_ready      (q_ready)
	);

	genvar g;
	generate
		for (g = 0; g < l1_cache_num; g++) begin : g_l1
			tex_l1_cache #(
				.tag_addr_w (tag_addr_w)
			) i_tex_l1_cache (
				.clk         (clk),
				.rst_n       (rst_n),
				.q_addrx     (q_addrx[g*ax +: ax]),
				.q_addry     (q_addry[g*ay +: ay]),
				.q_border    (q_border[g]),
				.q_valid     (q_valid[g]),
				.q_ready     (q_ready[g]),
				.s_rdata     (s_rdata[g*pw +: pw]),
				.s_rvalid    (s_rvalid[g]),
				.s_rready    (s_rready[g]),
				.miss_blk_x  (miss_blk_x[g*bx +: bx]),
				.miss_y      (miss_y[g*ay +: ay]),
				.miss_valid  (miss_valid[g]),
				.miss_ready  (miss_ready[g]),
				.fill_line   (fill_line),
				.fill_valid  (fill_valid[g]),
				.clear_start (clear_start),
				.clr_busy    (clr_busy[g])
			);
		end
	endgenerate

	tex_fetch_arbiter #(
		.l1_cache_num (l1_cache_num),
		.stride_w     (stride_w)
	) i_tex_fetch_arbiter (
		.clk            (clk),
		.rst_n          (rst_n),
		.param_addr     (param_addr),
		.param_stride   (param_stride),
		.endian         (endian),
		.miss_blk_x     (miss_blk_x),
		.miss_y         (miss_y),
		.miss_valid     (miss_valid),
		.miss_ready     (miss_ready),
		.fill_line      (fill_line),
		.fill_valid     (fill_valid),
		.clr_busy       (clr_busy),
		.clear_busy     (clear_busy),
		.m_axi4_araddr  (m_axi4_araddr),
		.m_axi4_arvalid (m_axi4_arvalid),
		.m_axi4_arready (m_axi4_arready),
		.m_axi4_rdata   (m_axi4_rdata),
		.m_axi4_rlast   (m_axi4_rlast),
		.m_axi4_rvalid  (m_axi4_rvalid),
		.m_axi4_rready  (m_axi4_rready)
	);

endmodule

`default_nettype wire

// File: tex_cache_golden.hex
// texture cache reads, one per line, all fields hex
// test  port  x    y    endian  expected pixel
// 1: cold miss on port 0
01 0 00d 005 0 5a5a1534
// 2: more pixels of the same line
02 0 008 005 0 5a5a1520
02 0 00f 005 0 5a5a153c
02 0 00a 005 0 5a5a1528
// 3: outside the 40 x 20 texture
03 0 028 000 0 00000000
03 1 003 014 0 00000000
03 0 fff fff 0 00000000
03 1 027 019 0 00000000
// 4: both ports miss together, two lines form one pair
04 0 002 007 0 5a5a1708
04 1 021 00c 0 5a5a1c84
04 0 019 012 0 5a5a2264
04 1 006 000 0 5a5a1018
// 5: component order reversed
05 1 014 003 1 50135a5a
05 1 017 003 1 5c135a5a
05 0 024 00a 1 901a5a5a
// 6: hit, clear, then refetch of the same pixel
06 0 00d 005 0 5a5a1534
06 0 009 005 0 5a5a1524

// File: tex_fetch_arbiter.sv
// ----------------------------------------------------------------------
// fetch arbiter
// round-robin grant over the L1 misses, one fixed burst per line,
// endian swap of each beat and line return to the requesting cache
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tex_fetch_arbiter #(
	parameter int l1_cache_num = 2,
	parameter int stride_w     = 16
) (
	input  logic                                  clk,
	input  logic                                  rst_n,

	input  logic [tex_axi_pkg::axi_addr_w-1:0]    param_addr,
	input  logic [stride_w-1:0]                   param_stride,
	input  logic                                  endian,

	input  logic [l1_cache_num*(tex_pix_pkg::addr_x_w-tex_pix_pkg::blk_x_size)-1:0] miss_blk_x,
	input  logic [l1_cache_num*tex_pix_pkg::addr_y_w-1:0] miss_y,
	input  logic [l1_cache_num-1:0]               miss_valid,
	output logic [l1_cache_num-1:0]               miss_ready,

	output logic [tex_pix_pkg::line_w-1:0]        fill_line,
	output logic [l1_cache_num-1:0]               fill_valid,

	input  logic [l1_cache_num-1:0]               clr_busy,
	output logic                                  clear_busy,

	output logic [tex_axi_pkg::axi_addr_w-1:0]    m_axi4_araddr,
	output logic                                  m_axi4_arvalid,
	input  logic                                  m_axi4_arready,
	input  logic [tex_axi_pkg::axi_data_w-1:0]    m_axi4_rdata,
	input  logic                                  m_axi4_rlast,
	input  logic                                  m_axi4_rvalid,
	output logic                                  m_axi4_rready
);

	localparam int aw         = tex_axi_pkg::axi_addr_w;
	localparam int pw         = tex_pix_pkg::pix_w;
	localparam int ay         = tex_pix_pkg::addr_y_w;
	localparam int bx         = tex_pix_pkg::addr_x_w - tex_pix_pkg::blk_x_size;
	localparam int id_w       = (l1_cache_num > 1) ? $clog2(l1_cache_num) : 1;
	localparam int beat_w     = $clog2(tex_axi_pkg::burst_beats);
	localparam int line_bytes = tex_axi_pkg::burst_beats * tex_axi_pkg::beat_bytes;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_addr = 2'd1;
	localparam logic [1:0] st_data = 2'd2;

	logic [1:0]            state;
	logic [id_w-1:0]       rr_ptr;
	logic [id_w-1:0]       gnt_sel;
	logic [id_w-1:0]       gnt_id;
	logic                  gnt_found;
	logic [beat_w-1:0]     beat_cnt;
	logic [bx-1:0]         sel_blk_x;
	logic [ay-1:0]         sel_y;
	tex_pix_pkg::tex_pix_u beat_in;
	tex_pix_pkg::tex_pix_u beat_out;

	assign clear_busy     = |clr_busy;
	assign m_axi4_arvalid = (state == st_addr);
	assign m_axi4_rready  = (state == st_data);
	assign sel_blk_x      = miss_blk_x[gnt_sel*bx +: bx];
	assign sel_y          = miss_y[gnt_sel*ay +: ay];

	// first pending miss at or after the pointer
	always_comb begin
		int cand;
		gnt_found = 1'b0;
		gnt_sel   = '0;
		for (int k = 0; k < l1_cache_num; k++) begin
			cand = (int'(rr_ptr) + k) % l1_cache_num;
			if (!gnt_found && miss_valid[cand]) begin
				gnt_found = 1'b1;
				gnt_sel   = id_w'(cand);
			end
		end
		for (int k = 0; k < l1_cache_num; k++) begin
			miss_ready[k] = (state == st_idle) && gnt_found && (gnt_sel == id_w'(k));
		end
	end

	// component order reversed when endian is set
	always_comb begin
		beat_in.raw  = m_axi4_rdata;
		beat_out.raw = beat_in.raw;
		if (endian) begin
			beat_out.comp.r = beat_in.comp.a;
			beat_out.comp.g = beat_in.comp.b;
			beat_out.comp.b = beat_in.comp.g;
			beat_out.comp.a = beat_in.comp.r;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			rr_ptr     <= '0;
			gnt_id     <= '0;
			beat_cnt   <= '0;
			fill_valid <= '0;
		end else begin
			fill_valid <= '0;
			case (state)
				st_idle: begin
					if (gnt_found) begin
						gnt_id <= gnt_sel;
						rr_ptr <= (gnt_sel == id_w'(l1_cache_num - 1)) ? '0 : gnt_sel + 1'b1;
						state  <= st_addr;
					end
				end
				st_addr: begin
					if (m_axi4_arready) begin
						beat_cnt <= '0;
						state    <= st_data;
					end
				end
				st_data: begin
					if (m_axi4_rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (m_axi4_rlast) begin
							fill_valid[gnt_id] <= 1'b1;
							state              <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// burst address and line assembly
	always_ff @(posedge clk) begin
		if (state == st_idle && gnt_found) begin
			m_axi4_araddr <= param_addr + aw'(sel_y) * aw'(param_stride)
			                 + aw'(sel_blk_x) * aw'(line_bytes);
		end
		if (state == st_data && m_axi4_rvalid) begin
			fill_line[beat_cnt*pw +: pw] <= beat_out.raw;
		end
	end

endmodule

`default_nettype wire

// File: tex_l1_cache.sv
// ----------------------------------------------------------------------
// L1 texture cache
// blocking direct-mapped cache of 8-pixel row lines, one request in
// flight, line fetch on miss and a walking clear of all tags
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tex_l1_cache #(
	parameter int tag_addr_w = 4
) (
	input  logic                                                   clk,
	input  logic                                                   rst_n,

	input  logic [tex_pix_pkg::addr_x_w-1:0]                       q_addrx,
	input  logic [tex_pix_pkg::addr_y_w-1:0]                       q_addry,
	input  logic                                                   q_border,
	input  logic                                                   q_valid,
	output logic                                                   q_ready,

	output logic [tex_pix_pkg::pix_w-1:0]                          s_rdata,
	output logic                                                   s_rvalid,
	input  logic                                                   s_rready,

	output logic [tex_pix_pkg::addr_x_w-tex_pix_pkg::blk_x_size-1:0] miss_blk_x,
	output logic [tex_pix_pkg::addr_y_w-1:0]                       miss_y,
	output logic                                                   miss_valid,
	input  logic                                                   miss_ready,

	input  logic [tex_pix_pkg::line_w-1:0]                         fill_line,
	input  logic                                                   fill_valid,

	input  logic                                                   clear_start,
	output logic                                                   clr_busy
);

	localparam int pw      = tex_pix_pkg::pix_w;
	localparam int bs      = tex_pix_pkg::blk_x_size;
	localparam int ay      = tex_pix_pkg::addr_y_w;
	localparam int bx      = tex_pix_pkg::addr_x_w - bs;
	localparam int ix_w    = tag_addr_w / 2;
	localparam int iy_w    = tag_addr_w - ix_w;
	localparam int entries = 1 << tag_addr_w;

	localparam logic [2:0] st_idle   = 3'd0;
	localparam logic [2:0] st_lookup = 3'd1;
	localparam logic [2:0] st_miss   = 3'd2;
	localparam logic [2:0] st_wait   = 3'd3;
	localparam logic [2:0] st_resp   = 3'd4;

	logic [2:0]            state;
	logic [bx-1:0]         req_blk_x;
	logic [bs-1:0]         req_pix;
	logic [ay-1:0]         req_y;
	logic                  req_border;
	logic [tag_addr_w-1:0] idx;
	logic                  hit;
	logic                  fill_we;
	logic [tag_addr_w-1:0] clr_idx;

	logic [entries-1:0]             tag_valid;
	logic [bx+ay-1:0]               tag_mem  [entries];
	logic [tex_pix_pkg::line_w-1:0] data_mem [entries];

	// index from the low bits of block x and y
	assign idx     = {req_y[iy_w-1:0], req_blk_x[ix_w-1:0]};
	assign hit     = tag_valid[idx] && (tag_mem[idx] == {req_blk_x, req_y});
	assign fill_we = (state == st_wait) && fill_valid;

	assign q_ready    = (state == st_idle) && !clr_busy;
	assign s_rvalid   = (state == st_resp);
	assign miss_valid = (state == st_miss);
	assign miss_blk_x = req_blk_x;
	assign miss_y     = req_y;

	// ------------------------------------------------------------------
	// request FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (q_valid && q_ready) begin
						state <= st_lookup;
					end
				end
				st_lookup: begin
					state <= (req_border || hit) ? st_resp : st_miss;
				end
				st_miss: begin
					if (miss_ready) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (fill_valid) begin
						state <= st_resp;
					end
				end
				st_resp: begin
					if (s_rready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request, line and pixel storage
	always_ff @(posedge clk) begin
		if (q_valid && q_ready) begin
			req_blk_x  <= q_addrx[tex_pix_pkg::addr_x_w-1:bs];
			req_pix    <= q_addrx[bs-1:0];
			req_y      <= q_addry;
			req_border <= q_border;
		end
		// border answers without looking at the line
		if (state == st_lookup) begin
			s_rdata <= req_border ? tex_pix_pkg::border_pix : data_mem[idx][req_pix*pw +: pw];
		end
		if (fill_we) begin
			data_mem[idx] <= fill_line;
			tag_mem[idx]  <= {req_blk_x, req_y};
			s_rdata       <= fill_line[req_pix*pw +: pw];
		end
	end

	// ------------------------------------------------------------------
	// valid bits and clear walk
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_valid <= '0;
			clr_busy  <= 1'b0;
			clr_idx   <= '0;
		end else begin
			if (clr_busy) begin
				tag_valid[clr_idx] <= 1'b0;
				clr_idx            <= clr_idx + 1'b1;
				if (clr_idx == tag_addr_w'(entries - 1)) begin
					clr_busy <= 1'b0;
				end
			end else if (clear_start) begin
				clr_busy <= 1'b1;
				clr_idx  <= '0;
			end
			if (fill_we) begin
				tag_valid[idx] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tex_pix_pkg.sv
// ----------------------------------------------------------------------
// texture pixel package
// pixel format, RGBA component view of a bus word, coordinate widths
// and the layout of one cache line
// ----------------------------------------------------------------------

`default_nettype none

package tex_pix_pkg;

	localparam int pix_w      = 32;
	localparam int comp_w     = 8;

	// texture coordinate widths
	localparam int addr_x_w   = 12;
	localparam int addr_y_w   = 12;

	// one line is a row of 2^blk_x_size pixels
	localparam int blk_x_size = 3;
	localparam int line_w     = pix_w << blk_x_size;

	typedef struct packed {
		logic [comp_w-1:0] r;
		logic [comp_w-1:0] g;
		logic [comp_w-1:0] b;
		logic [comp_w-1:0] a;
	} tex_comp_t;

	// a bus word seen as a plain word or as four components
	typedef union packed {
		logic [pix_w-1:0] raw;
		tex_comp_t        comp;
	} tex_pix_u;

	// returned for coordinates outside the texture
	localparam logic [pix_w-1:0] border_pix = '0;

endpackage

`default_nettype wire

// File: tex_req_dispatch.sv
// ----------------------------------------------------------------------
// request dispatcher
// one register stage per port, flags out-of-texture coordinates as
// border and forwards the request to the port's L1 cache
// ----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module tex_req_dispatch #(
	parameter int l1_cache_num = 2
) (
	input  logic                                           clk,
	input  logic                                           rst_n,

	input  logic [tex_pix_pkg::addr_x_w-1:0]               param_width,
	input  logic [tex_pix_pkg::addr_y_w-1:0]               param_height,

	input  logic [l1_cache_num*tex_pix_pkg::addr_x_w-1:0] s_araddrx,
	input  logic [l1_cache_num*tex_pix_pkg::addr_y_w-1:0] s_araddry,
	input  logic [l1_cache_num-1:0]                        s_arvalid,
	output logic [l1_cache_num-1:0]                        s_arready,

	output logic [l1_cache_num*tex_pix_pkg::addr_x_w-1:0] q_addrx,
	output logic [l1_cache_num*tex_pix_pkg::addr_y_w-1:0] q_addry,
	output logic [l1_cache_num-1:0]                        q_border,
	output logic [l1_cache_num-1:0]                        q_valid,
	input  logic [l1_cache_num-1:0]                        q_ready
);

	localparam int ax = tex_pix_pkg::addr_x_w;
	localparam int ay = tex_pix_pkg::addr_y_w;

	// keeps every s_arready low until the first cycle after reset
	logic rdy_en;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy_en <= 1'b0;
		end else begin
			rdy_en <= 1'b1;
		end
	end

	genvar p;
	generate
		for (p = 0; p < l1_cache_num; p++) begin : g_port
			logic          vld;
			logic [ax-1:0] in_x;
			logic [ay-1:0] in_y;

			assign in_x = s_araddrx[p*ax +: ax];
			assign in_y = s_araddry[p*ay +: ay];

			// stage takes a new request when empty or draining this cycle
			assign s_arready[p] = rdy_en & (~vld | q_ready[p]);
			assign q_valid[p]   = vld;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					vld <= 1'b0;
				end else if (s_arready[p]) begin
					vld <= s_arvalid[p];
				end
			end

			always_ff @(posedge clk) begin
				if (s_arready[p] && s_arvalid[p]) begin
					q_addrx[p*ax +: ax] <= in_x;
					q_addry[p*ay +: ay] <= in_y;
					q_border[p]         <= (in_x >= param_width) || (in_y >= param_height);
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire
